//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// width of data values, registers and instruction addresses
`define CPU_XLEN 16

// size of the register file
`define CPU_NREGS 8

// call and callr write the return address into this register
`define CPU_LINK_REG 7

// first instruction address fetched after reset
`define CPU_RESET_PC 0

`endif

//--- design/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [`CPU_XLEN-1:0] addr_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;
  typedef logic [4:0] opcode_t;

  // opcode class, taken from opcode bits 4..3
  localparam logic [1:0] CLS_ALU_R = 2'b00;
  localparam logic [1:0] CLS_JMP_R = 2'b01;
  localparam logic [1:0] CLS_ALU_I = 2'b10;
  localparam logic [1:0] CLS_JMP_I = 2'b11;

  // low three opcode bits inside the two alu classes
  localparam logic [2:0] ALU_ADD = 3'b000;
  localparam logic [2:0] ALU_SUB = 3'b001;
  localparam logic [2:0] ALU_CMP = 3'b010;
  localparam logic [2:0] ALU_AND = 3'b011;
  localparam logic [2:0] ALU_MOV = 3'b100;
  localparam logic [2:0] ALU_NOP = 3'b111;

  // low three opcode bits of call and callr inside the jump classes
  localparam logic [2:0] JMP_CALL = 3'b100;

  // instruction fields: opcode 4..0, rd 7..5, rs 10..8
  function automatic opcode_t op_of(word_t ir);
    return ir[4:0];
  endfunction

  function automatic reg_idx_t rd_of(word_t ir);
    return ir[7:5];
  endfunction

  function automatic reg_idx_t rs_of(word_t ir);
    return ir[10:8];
  endfunction

  // signed 8-bit immediate of the immediate alu class
  function automatic word_t imm_of(word_t ir);
    return {{(`CPU_XLEN-8){ir[15]}}, ir[15:8]};
  endfunction

  // absolute 11-bit target of the immediate jumps, zero extended
  function automatic addr_t tgt_of(word_t ir);
    return {{(`CPU_XLEN-11){1'b0}}, ir[15:5]};
  endfunction

endpackage

//--- design/de_if.sv
`timescale 1ns/100ps

// decode to execute pipeline register contents
interface de_if import cpu_pkg::*; ();

  // instruction in execute is live
  logic  valid;
  // instruction word and its own address
  word_t ir;
  addr_t pc;
  // operand values read in decode, bypass already applied
  word_t rd_val;
  word_t rs_val;

  // decode owns the register
  modport source (output valid, output ir, output pc, output rd_val, output rs_val);

  // execute only reads it
  modport sink (input valid, input ir, input pc, input rd_val, input rs_val);

endinterface

//--- design/fetch_unit.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module fetch_unit import cpu_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  word_t i_imem_data,
  output addr_t o_imem_addr,
  input  logic  i_dc_jump_i,
  input  logic  i_ex_jump_i,
  input  logic  i_ex_jump_r,
  input  addr_t i_ex_target,
  output logic  o_fd_valid,
  output word_t o_fd_ir,
  output addr_t o_fd_pc
);

  addr_t pc;
  addr_t pc_next;
  logic  ex_jump;
  logic  redirect;

  // an execute jump overrides anything decode asks for
  assign ex_jump  = i_ex_jump_i || i_ex_jump_r;
  assign redirect = ex_jump || i_dc_jump_i;

  // the memory answers in the same cycle, so the pc goes straight out
  assign o_imem_addr = pc;

  always_comb begin
    if (ex_jump) begin
      pc_next = i_ex_target;
    end else if (i_dc_jump_i) begin
      // j and call carry their target inside the word now in decode
      pc_next = tgt_of(o_fd_ir);
    end else begin
      pc_next = pc + addr_t'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc         <= addr_t'(`CPU_RESET_PC);
      o_fd_valid <= 1'b0;
    end else begin
      pc         <= pc_next;
      // whatever was fetched this cycle is on the wrong path after a redirect
      o_fd_valid <= !redirect;
    end
  end

  // word and address travel alongside the valid bit
  always_ff @(posedge i_clk) begin
    o_fd_ir <= i_imem_data;
    o_fd_pc <= pc;
  end

  // the testbench memory model indexes by this address
  a_imem_addr_known: assert property (@(posedge i_clk) disable iff (i_rst)
    !$isunknown(o_imem_addr))
    else $error("instruction address is unknown");

endmodule

//--- design/detect_jump.sv
`timescale 1ns/100ps

module detect_jump import cpu_pkg::*; (
  input  word_t i_ir_dc,
  input  word_t i_ir_ex,
  input  logic  i_alu_z,
  input  logic  i_alu_n,
  // j or call sitting in decode
  output logic  o_dc_jump_i,
  // jz or jn in execute whose flag is set
  output logic  o_ex_jump_i,
  // jr, callr, or jzr and jnr whose flag is set, in execute
  output logic  o_ex_jump_r
);

  opcode_t op_dc;
  opcode_t op_ex;
  logic    cond_ex;

  always_comb begin
    op_dc = op_of(i_ir_dc);
    op_ex = op_of(i_ir_ex);

    // bit 0 tests zero and bit 1 tests negative against the flags register
    cond_ex = (op_ex[0] && i_alu_z) || (op_ex[1] && i_alu_n);

    // unconditional immediate jumps need no flags and resolve one stage early
    o_dc_jump_i = op_dc[4:3] == CLS_JMP_I && op_dc[1:0] == 2'b00;

    o_ex_jump_i = op_ex[4:3] == CLS_JMP_I && cond_ex;

    // register jumps wait for execute since the target is a register value
    o_ex_jump_r = op_ex[4:3] == CLS_JMP_R && (op_ex[1:0] == 2'b00 || cond_ex);
  end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module decode_stage import cpu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_fd_valid,
  input  word_t    i_fd_ir,
  input  addr_t    i_fd_pc,
  input  logic     i_wb_valid,
  input  reg_idx_t i_wb_reg,
  input  word_t    i_wb_data,
  input  logic     i_ex_jump_i,
  input  logic     i_ex_jump_r,
  output word_t    o_dc_ir,
  de_if.source     de
);

  word_t    regs [`CPU_NREGS];
  reg_idx_t rd_idx;
  reg_idx_t rs_idx;
  word_t    rd_val;
  word_t    rs_val;
  logic     flush;

  // read one register, taking the write that execute presents this cycle
  function automatic word_t read_reg(reg_idx_t idx);
    word_t val;
    if (i_wb_valid && i_wb_reg == idx) begin
      val = i_wb_data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  // jump detection must not see a word that is not live
  assign o_dc_ir = i_fd_valid ? i_fd_ir : '0;

  assign rd_idx = rd_of(i_fd_ir);
  assign rs_idx = rs_of(i_fd_ir);

  // both operands are read for every class and execute picks what it needs
  always_comb begin
    rd_val = read_reg(rd_idx);
    rs_val = read_reg(rs_idx);
  end

  // a jump taken in execute kills the instruction now in decode
  assign flush = i_ex_jump_i || i_ex_jump_r;

  // a reset clears every register to zero
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_valid) begin
      regs[i_wb_reg] <= i_wb_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      de.valid <= 1'b0;
    end else begin
      de.valid <= i_fd_valid && !flush;
    end
  end

  // payload follows de.valid
  always_ff @(posedge i_clk) begin
    de.ir     <= i_fd_ir;
    de.pc     <= i_fd_pc;
    de.rd_val <= rd_val;
    de.rs_val <= rs_val;
  end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module execute_stage import cpu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  de_if.sink       de,
  output word_t    o_ex_ir,
  output logic     o_flag_z,
  output logic     o_flag_n,
  output addr_t    o_ex_target,
  output logic     o_wb_valid,
  output reg_idx_t o_wb_reg,
  output word_t    o_wb_data
);

  opcode_t  op;
  logic     is_alu;
  logic     is_link;
  word_t    src_b;
  word_t    alu_res;
  logic     alu_wr;
  logic     alu_flags;
  addr_t    link_pc;

  assign op = op_of(de.ir);

  assign is_alu  = op[4:3] == CLS_ALU_R || op[4:3] == CLS_ALU_I;
  // call and callr share their low bits and differ only in class
  assign is_link = (op[4:3] == CLS_JMP_I || op[4:3] == CLS_JMP_R) && op[2:0] == JMP_CALL;

  // second operand is either rs or the sign extended immediate
  assign src_b = op[4:3] == CLS_ALU_I ? imm_of(de.ir) : de.rs_val;

  always_comb begin
    alu_res   = '0;
    alu_wr    = 1'b0;
    alu_flags = 1'b0;
    if (is_alu) begin
      case (op[2:0])
        ALU_ADD: begin
          alu_res   = de.rd_val + src_b;
          alu_wr    = 1'b1;
          alu_flags = 1'b1;
        end
        ALU_SUB: begin
          alu_res   = de.rd_val - src_b;
          alu_wr    = 1'b1;
          alu_flags = 1'b1;
        end
        // cmp is a sub that only leaves its flags behind
        ALU_CMP: begin
          alu_res   = de.rd_val - src_b;
          alu_flags = 1'b1;
        end
        ALU_AND: begin
          alu_res   = de.rd_val & src_b;
          alu_wr    = 1'b1;
          alu_flags = 1'b1;
        end
        // mov copies the source and keeps the flags
        ALU_MOV: begin
          alu_res = src_b;
          alu_wr  = 1'b1;
        end
        ALU_NOP: alu_res = '0;
        // unlisted codes behave as nop
        default: alu_res = '0;
      endcase
    end
  end

  // flags hold the state left by the last flag setting instruction
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_flag_z <= 1'b0;
      o_flag_n <= 1'b0;
    end else if (de.valid && alu_flags) begin
      o_flag_z <= alu_res == '0;
      o_flag_n <= alu_res[`CPU_XLEN-1];
    end
  end

  // return address for call and callr
  assign link_pc = de.pc + addr_t'(1);

  // register jumps go to rs and immediate jumps to the absolute field
  assign o_ex_target = op[4:3] == CLS_JMP_R ? de.rs_val : tgt_of(de.ir);

  // zero word when dead, which detect_jump reads as add and not a jump
  assign o_ex_ir = de.valid ? de.ir : '0;

  // the write leaves in this cycle and decode stores it at the clock edge
  assign o_wb_valid = de.valid && (alu_wr || is_link);
  assign o_wb_reg   = is_link ? reg_idx_t'(`CPU_LINK_REG) : rd_of(de.ir);
  assign o_wb_data  = is_link ? link_pc : alu_res;

  // a live write must carry a known register and value into the register file
  a_wb_known: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_valid |-> !$isunknown({o_wb_reg, o_wb_data}))
    else $error("write back carries an unknown register or value");

endmodule

//--- design/cpu_core_top.sv
`timescale 1ns/100ps

module cpu_core_top import cpu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  output addr_t    o_imem_addr,
  input  word_t    i_imem_data,
  output logic     o_wb_valid,
  output reg_idx_t o_wb_reg,
  output word_t    o_wb_data
);

  // fetch to decode
  logic  fd_valid;
  word_t fd_ir;
  addr_t fd_pc;

  // masked words seen by jump detection
  word_t dc_ir;
  word_t ex_ir;

  // jump decisions and the execute side inputs they need
  logic  dc_jump_i;
  logic  ex_jump_i;
  logic  ex_jump_r;
  addr_t ex_target;
  logic  flag_z;
  logic  flag_n;

  // decode to execute register
  de_if de_bus ();

  fetch_unit u_fetch (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_imem_data (i_imem_data),
    .o_imem_addr (o_imem_addr),
    .i_dc_jump_i (dc_jump_i),
    .i_ex_jump_i (ex_jump_i),
    .i_ex_jump_r (ex_jump_r),
    .i_ex_target (ex_target),
    .o_fd_valid  (fd_valid),
    .o_fd_ir     (fd_ir),
    .o_fd_pc     (fd_pc)
  );

  // write back goes both to the top ports and into the register file
  decode_stage u_decode (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_fd_valid  (fd_valid),
    .i_fd_ir     (fd_ir),
    .i_fd_pc     (fd_pc),
    .i_wb_valid  (o_wb_valid),
    .i_wb_reg    (o_wb_reg),
    .i_wb_data   (o_wb_data),
    .i_ex_jump_i (ex_jump_i),
    .i_ex_jump_r (ex_jump_r),
    .o_dc_ir     (dc_ir),
    .de          (de_bus.source)
  );

  detect_jump u_detect (
    .i_ir_dc     (dc_ir),
    .i_ir_ex     (ex_ir),
    .i_alu_z     (flag_z),
    .i_alu_n     (flag_n),
    .o_dc_jump_i (dc_jump_i),
    .o_ex_jump_i (ex_jump_i),
    .o_ex_jump_r (ex_jump_r)
  );

  execute_stage u_execute (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .de          (de_bus.sink),
    .o_ex_ir     (ex_ir),
    .o_flag_z    (flag_z),
    .o_flag_n    (flag_n),
    .o_ex_target (ex_target),
    .o_wb_valid  (o_wb_valid),
    .o_wb_reg    (o_wb_reg),
    .o_wb_data   (o_wb_data)
  );

endmodule

//--- verif/cpu_core_tb.sv
`timescale 1ns/100ps
`include "cpu_macros.svh"

module cpu_core_tb import cpu_pkg::*; ();

  // opcodes written out from the instruction set rules
  localparam logic [4:0] OP_ADD   = 5'h00;
  localparam logic [4:0] OP_SUB   = 5'h01;
  localparam logic [4:0] OP_MOV   = 5'h04;
  localparam logic [4:0] OP_ADDI  = 5'h10;
  localparam logic [4:0] OP_SUBI  = 5'h11;
  localparam logic [4:0] OP_CMPI  = 5'h12;
  localparam logic [4:0] OP_ANDI  = 5'h13;
  localparam logic [4:0] OP_MOVI  = 5'h14;
  localparam logic [4:0] OP_JR    = 5'h08;
  localparam logic [4:0] OP_JZR   = 5'h09;
  localparam logic [4:0] OP_JNR   = 5'h0a;
  localparam logic [4:0] OP_CALLR = 5'h0c;
  localparam logic [4:0] OP_J     = 5'h18;
  localparam logic [4:0] OP_JZ    = 5'h19;
  localparam logic [4:0] OP_JN    = 5'h1a;
  localparam logic [4:0] OP_CALL  = 5'h1c;

  // cycles allowed between two expected register writes
  localparam int WAIT_LIMIT = 40;

  logic     i_clk;
  logic     i_rst;
  addr_t    o_imem_addr;
  word_t    i_imem_data;
  logic     o_wb_valid;
  reg_idx_t o_wb_reg;
  word_t    o_wb_data;

  word_t       imem [64];
  reg_idx_t    exp_reg [$];
  word_t       exp_val [$];
  logic [31:0] rng_state = 32'h18c4;

  cpu_core_top dut0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_imem_addr (o_imem_addr),
    .i_imem_data (i_imem_data),
    .o_wb_valid  (o_wb_valid),
    .o_wb_reg    (o_wb_reg),
    .o_wb_data   (o_wb_data)
  );

  always #50 i_clk = !i_clk;

  // the memory answers in the same cycle as the address
  assign i_imem_data = imem[o_imem_addr[5:0]];

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] next_rand8();
    rng_state = xorshift(rng_state);
    return rng_state[7:0];
  endfunction

  function automatic word_t sext8(logic [7:0] v);
    return {{8{v[7]}}, v};
  endfunction

  // encoders place the opcode in 4..0, rd in 7..5 and rs in 10..8
  function automatic word_t enc_alu_r(logic [4:0] op, logic [2:0] rd, logic [2:0] rs);
    return {5'b0, rs, rd, op};
  endfunction

  function automatic word_t enc_alu_i(logic [4:0] op, logic [2:0] rd, logic [7:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_jmp_i(logic [4:0] op, logic [10:0] tgt);
    return {tgt, op};
  endfunction

  function automatic word_t enc_jmp_r(logic [4:0] op, logic [2:0] rs);
    return {5'b0, rs, 3'b0, op};
  endfunction

  task automatic fail_run();
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // every word not loaded by a test jumps to itself, so the core just spins there
  task automatic clear_program();
    for (int a = 0; a < 64; a++) begin
      imem[a[5:0]] = {a[10:0], OP_J};
    end
    exp_reg.delete();
    exp_val.delete();
  endtask

  task automatic put(logic [5:0] addr, word_t w);
    imem[addr] = w;
  endtask

  task automatic expect_write(reg_idx_t r, word_t v);
    exp_reg.push_back(r);
    exp_val.push_back(v);
  endtask

  // reset is held for three cycles and the first of them can still let a write out
  task automatic apply_reset();
    @(posedge i_clk);
    i_rst <= 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(negedge i_clk);
      if (i > 0) begin
        check_value("o_wb_valid", 32'(o_wb_valid), 32'd0);
        check_value("o_imem_addr", 32'(o_imem_addr), 32'(`CPU_RESET_PC));
      end
      @(posedge i_clk);
    end
    i_rst <= 1'b0;
  endtask

  task automatic wait_write();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_wb_valid && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_wb_valid) begin
      $display("ERROR: no register write arrived within %0d cycles", WAIT_LIMIT);
      fail_run();
    end
  endtask

  // writes must arrive in program order, so a skipped instruction shows up as a mismatch
  task automatic check_writes();
    while (exp_reg.size() > 0) begin
      wait_write();
      check_value("o_wb_reg", 32'(o_wb_reg), 32'(exp_reg[0]));
      check_value("o_wb_data", 32'(o_wb_data), 32'(exp_val[0]));
      void'(exp_reg.pop_front());
      void'(exp_val.pop_front());
    end
  endtask

  task automatic check_quiet();
    repeat (8) begin
      @(negedge i_clk);
      check_value("o_wb_valid", 32'(o_wb_valid), 32'd0);
    end
  endtask

  task automatic test_alu();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
    word_t      r1;
    word_t      r2;
    $display("test: register and immediate alu");
    a = next_rand8();
    b = next_rand8();
    c = next_rand8();
    d = next_rand8();
    clear_program();
    put(6'd0, enc_alu_i(OP_MOVI, 3'd1, a));
    put(6'd1, enc_alu_i(OP_ADDI, 3'd1, b));
    put(6'd2, enc_alu_i(OP_MOVI, 3'd2, c));
    put(6'd3, enc_alu_r(OP_SUB, 3'd2, 3'd1));
    put(6'd4, enc_alu_i(OP_ANDI, 3'd2, d));
    put(6'd5, enc_alu_r(OP_ADD, 3'd3, 3'd2));
    put(6'd6, enc_alu_r(OP_MOV, 3'd4, 3'd3));
    put(6'd7, enc_alu_i(OP_SUBI, 3'd4, a));
    r1 = sext8(a);
    expect_write(3'd1, r1);
    r1 = r1 + sext8(b);
    expect_write(3'd1, r1);
    r2 = sext8(c);
    expect_write(3'd2, r2);
    r2 = r2 - r1;
    expect_write(3'd2, r2);
    r2 = r2 & sext8(d);
    expect_write(3'd2, r2);
    // r3 starts at zero after reset
    expect_write(3'd3, r2);
    expect_write(3'd4, r2);
    expect_write(3'd4, r2 - sext8(a));
    apply_reset();
    check_writes();
    check_quiet();
  endtask

  task automatic test_cond_jumps();
    $display("test: cmp with jz and jn");
    clear_program();
    put(6'd0, enc_alu_i(OP_MOVI, 3'd1, 8'd5));
    put(6'd1, enc_alu_i(OP_CMPI, 3'd1, 8'd5));
    put(6'd2, enc_jmp_i(OP_JZ, 11'd5));
    put(6'd3, enc_alu_i(OP_MOVI, 3'd2, 8'd1));
    put(6'd4, enc_alu_i(OP_MOVI, 3'd2, 8'd2));
    // 5 - 6 leaves zero clear and negative set
    put(6'd5, enc_alu_i(OP_CMPI, 3'd1, 8'd6));
    put(6'd6, enc_jmp_i(OP_JZ, 11'd9));
    put(6'd7, enc_alu_i(OP_MOVI, 3'd3, 8'd7));
    put(6'd8, enc_jmp_i(OP_JN, 11'd11));
    put(6'd9, enc_alu_i(OP_MOVI, 3'd3, 8'd9));
    put(6'd10, enc_alu_i(OP_MOVI, 3'd3, 8'd10));
    put(6'd11, enc_alu_i(OP_CMPI, 3'd1, 8'd1));
    put(6'd12, enc_jmp_i(OP_JN, 11'd14));
    put(6'd13, enc_alu_i(OP_MOVI, 3'd4, 8'd13));
    put(6'd14, enc_alu_i(OP_MOVI, 3'd5, 8'd14));
    expect_write(3'd1, 16'd5);
    expect_write(3'd3, 16'd7);
    expect_write(3'd4, 16'd13);
    expect_write(3'd5, 16'd14);
    apply_reset();
    check_writes();
    check_quiet();
  endtask

  task automatic test_jump_call();
    $display("test: j and call");
    clear_program();
    put(6'd0, enc_alu_i(OP_MOVI, 3'd1, 8'd1));
    put(6'd1, enc_jmp_i(OP_J, 11'd4));
    put(6'd2, enc_alu_i(OP_MOVI, 3'd1, 8'd2));
    put(6'd3, enc_alu_i(OP_MOVI, 3'd2, 8'd3));
    put(6'd4, enc_jmp_i(OP_CALL, 11'd8));
    put(6'd5, enc_alu_i(OP_MOVI, 3'd3, 8'd5));
    put(6'd8, enc_alu_r(OP_MOV, 3'd2, 3'd7));
    expect_write(3'd1, 16'd1);
    // call at address 4 links to 5
    expect_write(reg_idx_t'(`CPU_LINK_REG), 16'd5);
    expect_write(3'd2, 16'd5);
    apply_reset();
    check_writes();
    check_quiet();
  endtask

  task automatic test_reg_jumps();
    $display("test: jr, callr, jzr and jnr");
    clear_program();
    put(6'd0, enc_alu_i(OP_MOVI, 3'd1, 8'd6));
    put(6'd1, enc_jmp_r(OP_JR, 3'd1));
    put(6'd2, enc_alu_i(OP_MOVI, 3'd2, 8'd2));
    put(6'd3, enc_alu_i(OP_MOVI, 3'd2, 8'd3));
    put(6'd6, enc_alu_i(OP_MOVI, 3'd3, 8'd12));
    put(6'd7, enc_jmp_r(OP_CALLR, 3'd3));
    put(6'd8, enc_alu_i(OP_MOVI, 3'd4, 8'd8));
    put(6'd9, enc_alu_i(OP_CMPI, 3'd4, 8'd8));
    put(6'd10, enc_alu_i(OP_MOVI, 3'd5, 8'd20));
    put(6'd11, enc_jmp_r(OP_JZR, 3'd5));
    // subroutine at 12 returns through the link register
    put(6'd12, enc_alu_i(OP_MOVI, 3'd6, 8'd3));
    put(6'd13, enc_jmp_r(OP_JR, 3'd7));
    put(6'd14, enc_alu_i(OP_MOVI, 3'd6, 8'd99));
    put(6'd15, enc_alu_i(OP_MOVI, 3'd6, 8'd15));
    put(6'd20, enc_alu_i(OP_CMPI, 3'd6, 8'd4));
    put(6'd21, enc_alu_i(OP_MOVI, 3'd2, 8'd26));
    put(6'd22, enc_jmp_r(OP_JZR, 3'd2));
    put(6'd23, enc_alu_i(OP_MOVI, 3'd5, 8'd23));
    put(6'd24, enc_jmp_r(OP_JNR, 3'd2));
    put(6'd25, enc_alu_i(OP_MOVI, 3'd5, 8'd25));
    expect_write(3'd1, 16'd6);
    expect_write(3'd3, 16'd12);
    expect_write(reg_idx_t'(`CPU_LINK_REG), 16'd8);
    expect_write(3'd6, 16'd3);
    expect_write(3'd4, 16'd8);
    expect_write(3'd5, 16'd20);
    expect_write(3'd2, 16'd26);
    expect_write(3'd5, 16'd23);
    apply_reset();
    check_writes();
    check_quiet();
  endtask

  task automatic test_reset_restart();
    word_t step;
    $display("test: reset in mid-program");
    step = sext8(next_rand8());
    clear_program();
    for (int i = 0; i < 4; i++) begin
      put(i[5:0], enc_alu_i(OP_ADDI, 3'd1, step[7:0]));
    end
    expect_write(3'd1, step);
    expect_write(3'd1, step + step);
    apply_reset();
    check_writes();
    // the sum only starts over if r1 was cleared by the reset
    expect_write(3'd1, step);
    expect_write(3'd1, step + step);
    expect_write(3'd1, step + step + step);
    expect_write(3'd1, step + step + step + step);
    apply_reset();
    check_writes();
    check_quiet();
  endtask

  initial begin
    i_clk = 1'b0;
    i_rst = 1'b1;
    clear_program();
    test_alu();
    test_cond_jumps();
    test_jump_call();
    test_reg_jumps();
    test_reset_restart();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
design/cpu_pkg.sv
design/de_if.sv
design/fetch_unit.sv
design/detect_jump.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_core_top.sv
verif/cpu_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the simulation and run it, the result is read from the printed output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module cpu_core_tb \
  -o cpu_core_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/cpu_core_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx ">>> PASS" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
